// File: source/eth_tx_pkg.sv
`default_nettype none

package eth_tx_pkg;

  // --------------------------------------------------------------------------
  // sizes and constants
  // --------------------------------------------------------------------------
  localparam int fifo_depth   = 2048;
  localparam int fifo_count_w = 12;
  localparam int fifo_ptr_w   = $clog2(fifo_depth);
  localparam int min_payload  = 60;
  localparam int pad_cnt_w    = $clog2(min_payload + 1);
  localparam int preamble_len = 8;
  localparam int ifg_len      = 12;
  localparam int axil_addr_w  = 32;

  // seven 0x55 then the SFD, top byte goes out first
  localparam logic [63:0] preamble_word = 64'h5555_5555_5555_55d5;
  localparam logic [31:0] crc_poly_refl = 32'hedb8_8320;
  localparam logic [31:0] crc_seed      = 32'hffff_ffff;

  // register byte addresses
  localparam logic [axil_addr_w-1:0] reg_status    = 32'h0;
  localparam logic [axil_addr_w-1:0] reg_tx_data   = 32'h4;
  localparam logic [axil_addr_w-1:0] reg_frame_cnt = 32'h8;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // frame builder states
  localparam logic [1:0] bld_idle    = 2'd0;
  localparam logic [1:0] bld_payload = 2'd1;
  localparam logic [1:0] bld_pad     = 2'd2;
  localparam logic [1:0] bld_crc     = 2'd3;

  // sender states, one-hot
  localparam logic [2:0] snd_idle = 3'b001;
  localparam logic [2:0] snd_send = 3'b010;
  localparam logic [2:0] snd_gap  = 3'b100;

  // --------------------------------------------------------------------------
  // bundles
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } tx_byte_t;

  typedef struct packed {
    logic [axil_addr_w-1:0] awaddr;
    logic                   awvalid;
    logic [31:0]            wdata;
    logic [3:0]             wstrb;
    logic                   wvalid;
    logic                   bready;
    logic [axil_addr_w-1:0] araddr;
    logic                   arvalid;
    logic                   rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
  } axil_rsp_t;

  // one registered byte time on the rgmii pins
  typedef struct packed {
    logic       ctl;
    logic [3:0] rise;
    logic [3:0] fall;
  } rgmii_pair_t;

endpackage

`default_nettype wire

// File: source/axil_tx_regs.sv
`timescale 1ns/1ps
`default_nettype none

module axil_tx_regs (
  input  wire                                clock,
  input  wire                                reset,
  input  wire eth_tx_pkg::axil_req_t         axil_req,
  output eth_tx_pkg::axil_rsp_t              axil_rsp,
  output logic                               push,
  output eth_tx_pkg::tx_byte_t               push_byte,
  input  wire                                fifo_full,
  input  wire [eth_tx_pkg::fifo_count_w-1:0] fifo_count,
  input  wire                                tx_active,
  input  wire                                frame_done
);
  import eth_tx_pkg::*;

  logic        wr_accept;
  logic        rd_accept;
  logic        wr_is_data;
  logic        bvalid;
  logic [1:0]  bresp;
  logic        rvalid;
  logic [31:0] rdata;
  logic [31:0] rd_value;
  logic [31:0] frame_cnt;

  // --------------------------------------------------------------------------
  // handshakes
  // --------------------------------------------------------------------------
  // address and data must arrive together, one write in flight
  assign wr_accept  = axil_req.awvalid && axil_req.wvalid && !bvalid;
  assign rd_accept  = axil_req.arvalid && !rvalid;
  assign wr_is_data = (axil_req.awaddr == reg_tx_data);

  // byte in wdata[7:0], end-of-frame mark in wdata[8]
  assign push           = wr_accept && wr_is_data && !fifo_full;
  assign push_byte.data = axil_req.wdata[7:0];
  assign push_byte.last = axil_req.wdata[8];

  always_comb begin
    axil_rsp.awready = wr_accept;
    axil_rsp.wready  = wr_accept;
    axil_rsp.bresp   = bresp;
    axil_rsp.bvalid  = bvalid;
    axil_rsp.arready = rd_accept;
    axil_rsp.rdata   = rdata;
    axil_rsp.rresp   = resp_okay;
    axil_rsp.rvalid  = rvalid;
  end

  // read mux, unmapped reads give zero
  always_comb begin
    case (axil_req.araddr)
      reg_status:    rd_value = {4'h0, fifo_count, 14'h0, fifo_full, tx_active};
      reg_frame_cnt: rd_value = frame_cnt;
      default:       rd_value = 32'h0;
    endcase
  end

  // --------------------------------------------------------------------------
  // response and counter registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      bvalid    <= 1'b0;
      rvalid    <= 1'b0;
      frame_cnt <= 32'h0;
    end else begin
      if (wr_accept) begin
        bvalid <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid <= 1'b0;
      end
      if (rd_accept) begin
        rvalid <= 1'b1;
      end else if (axil_req.rready) begin
        rvalid <= 1'b0;
      end
      // wraps on overflow
      if (frame_done) begin
        frame_cnt <= frame_cnt + 32'd1;
      end
    end
  end

  // payload side of the responses
  always_ff @(posedge clock) begin
    if (wr_accept) begin
      bresp <= (wr_is_data && fifo_full) ? resp_slverr : resp_okay;
    end
    if (rd_accept) begin
      rdata <= rd_value;
    end
  end

  // a write response only follows an accepted write
  a_bvalid_after_write: assert property (
    @(posedge clock) disable iff (reset) $rose(bvalid) |-> $past(wr_accept)
  );

endmodule

`default_nettype wire

// File: source/tx_frame_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tx_frame_fifo (
  input  wire                                 clock,
  input  wire                                 reset,
  input  wire                                 push,
  input  wire eth_tx_pkg::tx_byte_t           push_byte,
  input  wire                                 pop,
  output eth_tx_pkg::tx_byte_t                head,
  output logic                                not_empty,
  output logic                                full,
  output logic [eth_tx_pkg::fifo_count_w-1:0] count,
  output logic [eth_tx_pkg::fifo_count_w-1:0] frames_ready
);
  import eth_tx_pkg::*;

  tx_byte_t              mem [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic                  do_push;
  logic                  do_pop;

  assign not_empty = (count != '0);
  assign full      = (count == fifo_count_w'(fifo_depth));
  assign do_push   = push && !full;
  assign do_pop    = pop && not_empty;
  // head read straight from the array
  assign head      = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= push_byte;
    end
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      frames_ready <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + fifo_count_w'(do_push) - fifo_count_w'(do_pop);
      // complete frames = last marks still held
      frames_ready <= frames_ready + fifo_count_w'(do_push && push_byte.last)
                                   - fifo_count_w'(do_pop && head.last);
    end
  end

  a_no_pop_empty: assert property (
    @(posedge clock) disable iff (reset) pop |-> not_empty
  );

  a_frames_le_count: assert property (
    @(posedge clock) disable iff (reset) frames_ready <= count
  );

endmodule

`default_nettype wire

// File: source/crc32_eth.sv
`timescale 1ns/1ps
`default_nettype none

module crc32_eth (
  input  wire        clock,
  input  wire        reset,
  input  wire        clear,
  input  wire        enable,
  input  wire  [7:0] data,
  output logic [31:0] crc
);
  import eth_tx_pkg::*;

  logic [31:0] crc_reg;
  logic [31:0] base;

  // one byte through the reflected polynomial, lsb first
  function automatic logic [31:0] crc_step(input logic [31:0] value, input logic [7:0] byte_in);
    logic [31:0] r;
    r = value ^ {24'h0, byte_in};
    for (int i = 0; i < 8; i++) begin
      r = r[0] ? ((r >> 1) ^ crc_poly_refl) : (r >> 1);
    end
    return r;
  endfunction

  // clear seeds first so a byte on the same cycle starts a new frame
  assign base = clear ? crc_seed : crc_reg;

  always_ff @(posedge clock) begin
    if (reset) begin
      crc_reg <= crc_seed;
    end else if (enable) begin
      crc_reg <= crc_step(base, data);
    end else if (clear) begin
      crc_reg <= crc_seed;
    end
  end

  // final inversion, byte 0 goes on the wire first
  assign crc = ~crc_reg;

endmodule

`default_nettype wire

// File: source/frame_builder.sv
`timescale 1ns/1ps
`default_nettype none

module frame_builder (
  input  wire                                clock,
  input  wire                                reset,
  input  wire eth_tx_pkg::tx_byte_t          head,
  input  wire                                not_empty,
  input  wire [eth_tx_pkg::fifo_count_w-1:0] frames_ready,
  output logic                               pop,
  output logic                               crc_clear,
  output logic                               crc_enable,
  output logic [7:0]                         crc_data,
  input  wire  [31:0]                        crc,
  output logic [7:0]                         tx_data,
  output logic                               tx_enable,
  input  wire                                active
);
  import eth_tx_pkg::*;

  logic [1:0]           state;
  logic [pad_cnt_w-1:0] byte_cnt;
  logic [pad_cnt_w-1:0] cnt_next;
  logic [1:0]           crc_idx;
  logic                 start;
  logic [7:0]           next_byte;

  // a whole frame is queued and the sender finished its gap
  assign start = (state == bld_idle) && (frames_ready != '0) && !active;

  // byte count saturates once the minimum length is reached
  assign cnt_next = (byte_cnt == pad_cnt_w'(min_payload)) ? byte_cnt : byte_cnt + 1'b1;

  always_comb begin
    case (state)
      bld_pad: next_byte = 8'h00;
      bld_crc: next_byte = crc[{crc_idx, 3'b000} +: 8];
      default: next_byte = head.data;
    endcase
  end

  // --------------------------------------------------------------------------
  // fifo and crc strobes
  // --------------------------------------------------------------------------
  assign pop        = start || (state == bld_payload);
  assign crc_clear  = (state == bld_idle);
  assign crc_enable = start || (state == bld_payload) || (state == bld_pad);
  // crc absorbs each byte on the edge it enters tx_data
  assign crc_data   = next_byte;

  always_ff @(posedge clock) begin
    tx_data <= next_byte;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= bld_idle;
      tx_enable <= 1'b0;
      byte_cnt  <= '0;
      crc_idx   <= 2'd0;
    end else begin
      case (state)
        bld_idle: begin
          tx_enable <= start;
          byte_cnt  <= pad_cnt_w'(1);
          crc_idx   <= 2'd0;
          // a one byte frame always needs padding
          if (start) begin
            state <= head.last ? bld_pad : bld_payload;
          end
        end
        bld_payload: begin
          byte_cnt <= cnt_next;
          if (head.last) begin
            state <= (cnt_next < pad_cnt_w'(min_payload)) ? bld_pad : bld_crc;
          end
        end
        bld_pad: begin
          byte_cnt <= cnt_next;
          if (cnt_next == pad_cnt_w'(min_payload)) begin
            state <= bld_crc;
          end
        end
        default: begin
          // tx_enable drops one cycle after the last crc byte
          crc_idx <= crc_idx + 2'd1;
          if (crc_idx == 2'd3) begin
            state <= bld_idle;
          end
        end
      endcase
    end
  end

  a_pop_not_empty: assert property (
    @(posedge clock) disable iff (reset) pop |-> not_empty
  );

endmodule

`default_nettype wire

// File: source/rgmii_send.sv
`timescale 1ns/1ps
`default_nettype none

module rgmii_send (
  input  wire        clock,
  input  wire        reset,
  input  wire  [7:0] tx_data,
  input  wire        tx_enable,
  output logic       active,
  output logic       frame_done,
  output logic [3:0] rgmii_txd,
  output logic       rgmii_tx_ctl
);
  import eth_tx_pkg::*;

  logic [8*preamble_len-1:0] shift_reg;
  logic [2:0]                state;
  logic [3:0]                bytes_left;
  logic                      sending;
  rgmii_pair_t               pair;

  // --------------------------------------------------------------------------
  // preamble shift register
  // --------------------------------------------------------------------------
  assign sending    = tx_enable || (state == snd_send);
  assign active     = sending || (state == snd_gap);
  assign frame_done = (state == snd_gap) && (bytes_left == 4'd0);

  // idle keeps the preamble loaded, payload follows it out the top
  always_ff @(posedge clock) begin
    if (sending) begin
      shift_reg <= {shift_reg[8*preamble_len-9:0], tx_data};
    end else begin
      shift_reg <= preamble_word;
    end
  end

  // --------------------------------------------------------------------------
  // state machine
  // --------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= snd_idle;
      bytes_left <= 4'd0;
    end else begin
      case (state)
        snd_idle: begin
          if (tx_enable) begin
            state      <= snd_send;
            bytes_left <= 4'(preamble_len - 1);
          end
        end
        snd_send: begin
          // purge count restarts while payload keeps coming
          if (tx_enable) begin
            bytes_left <= 4'(preamble_len - 1);
          end else if (bytes_left != 4'd0) begin
            bytes_left <= bytes_left - 4'd1;
          end else begin
            bytes_left <= 4'(ifg_len - 1);
            state      <= snd_gap;
          end
        end
        snd_gap: begin
          if (bytes_left != 4'd0) begin
            bytes_left <= bytes_left - 4'd1;
          end else begin
            state <= snd_idle;
          end
        end
        default: state <= snd_idle;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // ddr output stage
  // --------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    pair.rise <= shift_reg[8*preamble_len-5 -: 4];
    pair.fall <= shift_reg[8*preamble_len-1 -: 4];
    if (reset) begin
      pair.ctl <= 1'b0;
    end else begin
      pair.ctl <= sending;
    end
  end

  // low nibble in the high half, high nibble in the low half
  assign rgmii_txd    = clock ? pair.rise : pair.fall;
  // no tx errors so both halves carry the enable
  assign rgmii_tx_ctl = pair.ctl;

endmodule

`default_nettype wire

// File: source/eth_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module eth_tx_top (
  input  wire                        clock,
  input  wire                        reset,
  input  wire eth_tx_pkg::axil_req_t axil_req,
  output eth_tx_pkg::axil_rsp_t      axil_rsp,
  output logic [3:0]                 rgmii_txd,
  output logic                       rgmii_tx_ctl,
  output logic                       rgmii_txc
);
  import eth_tx_pkg::*;

  // host to fifo
  logic                    push;
  tx_byte_t                push_byte;
  logic                    fifo_full;
  logic [fifo_count_w-1:0] fifo_count;
  // fifo to builder
  tx_byte_t                head;
  logic                    not_empty;
  logic [fifo_count_w-1:0] frames_ready;
  logic                    pop;
  // builder and crc
  logic                    crc_clear;
  logic                    crc_enable;
  logic [7:0]              crc_data;
  logic [31:0]             crc;
  // builder to sender
  logic [7:0]              tx_data;
  logic                    tx_enable;
  logic                    tx_active;
  logic                    frame_done;

  // forwarded clock, edges line up with the ddr data
  assign rgmii_txc = clock;

  axil_tx_regs regs (
    .clock      (clock),
    .reset      (reset),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp),
    .push       (push),
    .push_byte  (push_byte),
    .fifo_full  (fifo_full),
    .fifo_count (fifo_count),
    .tx_active  (tx_active),
    .frame_done (frame_done)
  );

  tx_frame_fifo fifo (
    .clock        (clock),
    .reset        (reset),
    .push         (push),
    .push_byte    (push_byte),
    .pop          (pop),
    .head         (head),
    .not_empty    (not_empty),
    .full         (fifo_full),
    .count        (fifo_count),
    .frames_ready (frames_ready)
  );

  frame_builder builder (
    .clock        (clock),
    .reset        (reset),
    .head         (head),
    .not_empty    (not_empty),
    .frames_ready (frames_ready),
    .pop          (pop),
    .crc_clear    (crc_clear),
    .crc_enable   (crc_enable),
    .crc_data     (crc_data),
    .crc          (crc),
    .tx_data      (tx_data),
    .tx_enable    (tx_enable),
    .active       (tx_active)
  );

  crc32_eth crc_gen (
    .clock  (clock),
    .reset  (reset),
    .clear  (crc_clear),
    .enable (crc_enable),
    .data   (crc_data),
    .crc    (crc)
  );

  rgmii_send sender (
    .clock        (clock),
    .reset        (reset),
    .tx_data      (tx_data),
    .tx_enable    (tx_enable),
    .active       (tx_active),
    .frame_done   (frame_done),
    .rgmii_txd    (rgmii_txd),
    .rgmii_tx_ctl (rgmii_tx_ctl)
  );

endmodule

`default_nettype wire

// File: verif/tb_eth_tx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eth_tx;
  import eth_tx_pkg::*;

  logic       clock;
  logic       reset;
  axil_req_t  axil_req;
  axil_rsp_t  axil_rsp;
  logic [3:0] rgmii_txd;
  logic       rgmii_tx_ctl;
  logic       rgmii_txc;

  integer     seed;
  int         checks;
  int         errors;
  // raised once any wait loop runs out so that later waits fall through
  logic       stalled;

  logic [7:0] payload_q[$];
  logic [7:0] exp_q[$];
  logic [7:0] hold_q[$];
  logic [7:0] next_q[$];
  logic [7:0] frame_q[$];
  int         frame_gap;

  // rgmii monitor state
  logic [7:0] rx_q[$];
  int         len_q[$];
  int         gap_q[$];
  logic       mon_ctl;
  logic [3:0] mon_lo;
  logic [3:0] mon_hi;
  logic [1:0] mon_txc;
  logic       in_burst;
  int         burst_len;
  int         idle_run;

  eth_tx_top dut_i (
    .clock        (clock),
    .reset        (reset),
    .axil_req     (axil_req),
    .axil_rsp     (axil_rsp),
    .rgmii_txd    (rgmii_txd),
    .rgmii_tx_ctl (rgmii_tx_ctl),
    .rgmii_txc    (rgmii_txc)
  );

  always #2 clock = ~clock;

  // ------------------------------------------------------------------------
  // rgmii monitor
  // ------------------------------------------------------------------------
  // low nibble sampled mid high phase and high nibble mid low phase
  always @(posedge clock) begin
    #1;
    mon_ctl    = rgmii_tx_ctl;
    mon_lo     = rgmii_txd;
    mon_txc[1] = rgmii_txc;
    #2;
    mon_hi     = rgmii_txd;
    mon_txc[0] = rgmii_txc;
    if (reset) begin
      in_burst  = 1'b0;
      burst_len = 0;
      idle_run  = 0;
    end else if (mon_ctl) begin
      // idle byte times before this burst go with it
      if (!in_burst) begin
        gap_q.push_back(idle_run);
        burst_len = 0;
        idle_run  = 0;
      end
      in_burst = 1'b1;
      rx_q.push_back({mon_hi, mon_lo});
      burst_len++;
      // forwarded clock high in the first half and low in the second
      check_value("rgmii_txc", mon_txc, 2'b10);
    end else begin
      if (in_burst) begin
        len_q.push_back(burst_len);
      end
      in_burst = 1'b0;
      idle_run++;
    end
  end

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
    end
  endtask

  task automatic report_timeout(input string why);
    errors++;
    stalled = 1'b1;
    $display("timeout: %s", why);
  endtask

  task automatic apply_reset();
    @(negedge clock);
    reset    = 1'b1;
    axil_req = '0;
    repeat (3) @(negedge clock);
    reset = 1'b0;
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int n;
    n = 0;
    @(negedge clock);
    axil_req.awaddr  = addr;
    axil_req.awvalid = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hf;
    axil_req.wvalid  = 1'b1;
    axil_req.bready  = 1'b1;
    #1;
    while (!(axil_rsp.awready && axil_rsp.wready) && !stalled) begin
      @(negedge clock);
      #1;
      n++;
      if (n >= 50) report_timeout("write address and data were never accepted");
    end
    @(posedge clock);
    @(negedge clock);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    n = 0;
    #1;
    while (!axil_rsp.bvalid && !stalled) begin
      @(negedge clock);
      #1;
      n++;
      if (n >= 50) report_timeout("write response never arrived");
    end
    resp = axil_rsp.bresp;
    @(posedge clock);
    @(negedge clock);
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
    int n;
    n = 0;
    @(negedge clock);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    axil_req.rready  = 1'b1;
    #1;
    while (!axil_rsp.arready && !stalled) begin
      @(negedge clock);
      #1;
      n++;
      if (n >= 50) report_timeout("read address was never accepted");
    end
    @(posedge clock);
    @(negedge clock);
    axil_req.arvalid = 1'b0;
    n = 0;
    #1;
    while (!axil_rsp.rvalid && !stalled) begin
      @(negedge clock);
      #1;
      n++;
      if (n >= 50) report_timeout("read data never arrived");
    end
    data = axil_rsp.rdata;
    // every read answers OKAY
    check_value("rresp", axil_rsp.rresp, 2'b00);
    @(posedge clock);
    @(negedge clock);
    axil_req.rready = 1'b0;
  endtask

  // poll status until the sender has left its gap
  task automatic wait_tx_idle();
    logic [31:0] status;
    int          n;
    n = 0;
    axil_read(reg_status, status);
    while (status[0] && !stalled) begin
      n++;
      if (n >= 100) report_timeout("sender stayed active");
      axil_read(reg_status, status);
    end
  endtask

  task automatic random_payload(input int len);
    logic [31:0] rnd;
    int          i;
    payload_q.delete();
    for (i = 0; i < len; i++) begin
      rnd = $random(seed);
      payload_q.push_back(rnd[7:0]);
    end
  endtask

  // last byte carries the end-of-frame mark in bit 8
  task automatic send_frame();
    logic [1:0] resp;
    int         i;
    for (i = 0; i < payload_q.size(); i++) begin
      axil_write(reg_tx_data, {23'h0, i == payload_q.size() - 1, payload_q[i]}, resp);
      check_value("bresp", resp, 2'b00);
    end
  endtask

  task automatic capture_frame();
    int n;
    int len;
    int i;
    n = 0;
    while (len_q.size() == 0 && !stalled) begin
      @(negedge clock);
      n++;
      if (n >= 4000) report_timeout("no frame appeared on the rgmii pins");
    end
    frame_q.delete();
    frame_gap = 0;
    if (len_q.size() != 0) begin
      len       = len_q.pop_front();
      frame_gap = gap_q.pop_front();
      for (i = 0; i < len; i++) begin
        frame_q.push_back(rx_q.pop_front());
      end
    end
  endtask

  // reflected crc-32 taking one data bit at a time lsb first
  function automatic logic [31:0] crc_update(input logic [31:0] crc_in, input logic [7:0] b);
    logic [31:0] c;
    logic        fb;
    int          k;
    c = crc_in;
    for (k = 0; k < 8; k++) begin
      fb = c[0] ^ b[k];
      c  = {1'b0, c[31:1]};
      if (fb) c = c ^ 32'hedb8_8320;
    end
    return c;
  endfunction

  // preamble, sfd, zero padded payload, then fcs low byte first
  task automatic build_expected();
    logic [7:0]  pad_q[$];
    logic [31:0] crc;
    int          i;
    exp_q.delete();
    repeat (7) exp_q.push_back(8'h55);
    exp_q.push_back(8'hd5);
    pad_q = payload_q;
    while (pad_q.size() < 60) pad_q.push_back(8'h00);
    crc = 32'hffff_ffff;
    for (i = 0; i < pad_q.size(); i++) begin
      exp_q.push_back(pad_q[i]);
      crc = crc_update(crc, pad_q[i]);
    end
    crc = ~crc;
    exp_q.push_back(crc[7:0]);
    exp_q.push_back(crc[15:8]);
    exp_q.push_back(crc[23:16]);
    exp_q.push_back(crc[31:24]);
  endtask

  task automatic check_frame();
    int i;
    check_value("frame length", frame_q.size(), exp_q.size());
    for (i = 0; i < frame_q.size() && i < exp_q.size(); i++) begin
      check_value($sformatf("frame byte %0d", i), frame_q[i], exp_q[i]);
    end
  endtask

  // ------------------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------------------
  task automatic reset_state_reads();
    logic [31:0] rd;
    axil_read(reg_status, rd);
    check_value("status after reset", rd, 32'h0);
    axil_read(reg_frame_cnt, rd);
    check_value("frame_cnt after reset", rd, 32'h0);
  endtask

  task automatic random_frame_100();
    random_payload(100);
    send_frame();
    build_expected();
    capture_frame();
    check_frame();
  endtask

  task automatic padded_short_frame();
    random_payload(10);
    send_frame();
    build_expected();
    capture_frame();
    check_frame();
  endtask

  task automatic back_to_back_frames();
    logic [31:0] rd;
    wait_tx_idle();
    apply_reset();
    random_payload(64);
    send_frame();
    build_expected();
    hold_q = exp_q;
    // second one is short so it is padded too
    random_payload(20);
    send_frame();
    build_expected();
    next_q = exp_q;
    exp_q  = hold_q;
    capture_frame();
    check_frame();
    exp_q = next_q;
    capture_frame();
    check_frame();
    check_value("gap_at_least_12", frame_gap >= 12, 1);
    wait_tx_idle();
    axil_read(reg_frame_cnt, rd);
    check_value("frame_cnt", rd, 32'd2);
  endtask

  task automatic fifo_overflow();
    logic [1:0]  resp;
    logic [31:0] rd;
    int          okay_cnt;
    int          i;
    okay_cnt = 0;
    for (i = 0; i < 2048; i++) begin
      axil_write(reg_tx_data, {24'h0, i[7:0]}, resp);
      if (resp == 2'b00) okay_cnt++;
    end
    check_value("okay responses while filling", okay_cnt, 2048);
    axil_write(reg_tx_data, 32'h0000_00a5, resp);
    check_value("bresp on full fifo", resp, 2'b10);
    axil_read(reg_status, rd);
    check_value("status full bit", rd[1], 1'b1);
    check_value("status when full", rd, 32'h0800_0002);
  endtask

  initial begin
    clock    = 1'b0;
    reset    = 1'b1;
    axil_req = '0;
    seed     = 32'h595a3287;
    checks   = 0;
    errors   = 0;
    stalled  = 1'b0;
    apply_reset();
    reset_state_reads();
    random_frame_100();
    padded_short_frame();
    back_to_back_frames();
    fifo_overflow();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
source/eth_tx_pkg.sv
source/axil_tx_regs.sv
source/tx_frame_fifo.sv
source/crc32_eth.sv
source/frame_builder.sv
source/rgmii_send.sv
source/eth_tx_top.sv
verif/tb_eth_tx.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_eth_tx
FILELIST = tb.f
BUILD    = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Simulation finished: PASS$$"

clean:
	rm -rf $(BUILD)
